//--- logic/rv_isa_pkg.sv
// RV64I encoding subset for this core only; funct values cover the supported instructions
package rv_isa_pkg;

    typedef logic [63:0] xlen_t;     // data word
    typedef logic [31:0] inst_t;     // instruction word
    typedef logic [4:0]  reg_idx_t;  // architectural register index

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_t;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_DWORD   = 3'b011;  // ld / sd width
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    localparam inst_t EBREAK = 32'h0010_0073;

endpackage

//--- logic/pipe_pkg.sv
// pipeline-internal encodings; data memory is doubleword addressed, depth a power of two
package pipe_pkg;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,     // signed compare
        PASS_B   // lui and jal link value
    } alu_op_e;

    typedef enum logic {
        ALU,
        MEM
    } wb_src_e;

    // byte offset bits dropped to form the doubleword index
    localparam int DWORD_SHIFT = 3;

    // index width of the data memory, at least one bit
    function automatic int dmem_idx_bits(input int words);
        return (words > 1) ? $clog2(words) : 1;
    endfunction

endpackage

//--- logic/pipe_bus_if.sv
// stage bundle fields are only meaningful while valid is high; op_a carries the result after EX
`timescale 1ns/10ps

interface stage_bus_if;
    logic                 valid;
    rv_isa_pkg::xlen_t    pc;
    rv_isa_pkg::reg_idx_t rd;
    logic                 reg_wen;
    pipe_pkg::alu_op_e    alu_op;
    rv_isa_pkg::xlen_t    op_a;        // operand a, later the stage result
    rv_isa_pkg::xlen_t    op_b;
    rv_isa_pkg::xlen_t    store_data;
    logic                 mem_read;
    logic                 mem_write;
    pipe_pkg::wb_src_e    wb_src;
    logic                 illegal;
    logic                 halt;

    modport src (output valid, pc, rd, reg_wen, alu_op, op_a, op_b, store_data,
                 mem_read, mem_write, wb_src, illegal, halt);
    modport dst (input valid, pc, rd, reg_wen, alu_op, op_a, op_b, store_data,
                 mem_read, mem_write, wb_src, illegal, halt);
endinterface

interface regfile_if;
    rv_isa_pkg::reg_idx_t raddr1;
    rv_isa_pkg::xlen_t    rdata1;
    rv_isa_pkg::reg_idx_t raddr2;
    rv_isa_pkg::xlen_t    rdata2;
    logic                 wen;
    rv_isa_pkg::reg_idx_t waddr;
    rv_isa_pkg::xlen_t    wdata;

    modport rd     (output raddr1, raddr2, input rdata1, rdata2);  // decode side
    modport rd_srv (input raddr1, raddr2, output rdata1, rdata2);  // register file side
    modport wr     (input wen, waddr, wdata);                      // register file write
endinterface

//--- logic/fetch_stage.sv
// instruction memory is read combinationally; stall and redirect are never high together
`timescale 1ns/10ps

module fetch_stage #(
    parameter rv_isa_pkg::xlen_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              redirect_i,
    input  rv_isa_pkg::xlen_t redirect_pc_i,
    output rv_isa_pkg::xlen_t imem_addr_o,
    input  rv_isa_pkg::inst_t imem_rdata_i,
    input  logic              halt_i,
    output logic              id_valid_o,
    output rv_isa_pkg::xlen_t id_pc_o,
    output rv_isa_pkg::inst_t id_inst_o
);
    rv_isa_pkg::xlen_t pc_q;

    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_PC;
            id_valid_o <= 1'b0;
        end else if (halt_i) begin
            id_valid_o <= 1'b0;            // frozen for good
        end else if (redirect_i) begin
            pc_q       <= redirect_pc_i;
            id_valid_o <= 1'b0;            // squash the wrong-path slot
        end else if (!stall_i) begin
            pc_q       <= pc_q + 64'd4;
            id_valid_o <= 1'b1;
        end
    end

    // IF/ID payload, held while stalled
    always_ff @(posedge clk) begin
        if (!stall_i && !redirect_i) begin
            id_pc_o   <= pc_q;
            id_inst_o <= imem_rdata_i;
        end
    end
endmodule

//--- logic/decode_stage.sv
// branches resolve here with forwarded operands; nothing issues after an ebreak until reset
`timescale 1ns/10ps

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 id_valid_i,
    input  rv_isa_pkg::xlen_t    id_pc_i,
    input  rv_isa_pkg::inst_t    id_inst_i,
    regfile_if.rd                rf,
    input  rv_isa_pkg::reg_idx_t ex_rd_i,
    input  logic                 ex_wen_i,
    input  logic                 ex_load_i,
    input  rv_isa_pkg::xlen_t    ex_result_i,
    input  rv_isa_pkg::reg_idx_t mem_rd_i,
    input  logic                 mem_wen_i,
    input  rv_isa_pkg::xlen_t    mem_result_i,
    output logic                 stall_o,
    output logic                 redirect_o,
    output rv_isa_pkg::xlen_t    redirect_pc_o,
    stage_bus_if.src             ex_bus
);
    rv_isa_pkg::opcode_t  opcode;
    rv_isa_pkg::reg_idx_t rd, rs1, rs2;
    logic [2:0]           f3;
    logic [6:0]           f7;
    rv_isa_pkg::xlen_t    imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_isa_pkg::xlen_t    imm, rs1_val, rs2_val, op_b;
    pipe_pkg::alu_op_e    alu_op;
    logic use_imm, use_rs1, use_rs2, reg_wen, mem_rd, mem_wr;
    logic is_br, is_jal, illegal, halt;
    logic dec_valid, load_use, taken, issue, halt_seen_q;

    assign opcode = rv_isa_pkg::opcode_t'(id_inst_i[6:0]);
    assign rd     = id_inst_i[11:7];
    assign f3     = id_inst_i[14:12];
    assign rs1    = id_inst_i[19:15];
    assign rs2    = id_inst_i[24:20];
    assign f7     = id_inst_i[31:25];

    assign imm_i = {{52{id_inst_i[31]}}, id_inst_i[31:20]};
    assign imm_s = {{52{id_inst_i[31]}}, id_inst_i[31:25], id_inst_i[11:7]};
    assign imm_b = {{51{id_inst_i[31]}}, id_inst_i[31], id_inst_i[7], id_inst_i[30:25],
                    id_inst_i[11:8], 1'b0};
    assign imm_u = {{32{id_inst_i[31]}}, id_inst_i[31:12], 12'b0};
    assign imm_j = {{43{id_inst_i[31]}}, id_inst_i[31], id_inst_i[19:12], id_inst_i[20],
                    id_inst_i[30:21], 1'b0};

    always_comb begin
        alu_op  = pipe_pkg::ADD;
        imm     = imm_i;
        use_imm = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        reg_wen = 1'b0;
        mem_rd  = 1'b0;
        mem_wr  = 1'b0;
        is_br   = 1'b0;
        is_jal  = 1'b0;
        illegal = 1'b0;
        halt    = 1'b0;
        case (opcode)
            rv_isa_pkg::OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                reg_wen = 1'b1;
                case (f3)
                    rv_isa_pkg::F3_ADD_SUB:
                        alu_op = (f7 == rv_isa_pkg::F7_SUB) ? pipe_pkg::SUB : pipe_pkg::ADD;
                    rv_isa_pkg::F3_SLT: alu_op = pipe_pkg::SLT;
                    rv_isa_pkg::F3_XOR: alu_op = pipe_pkg::XOR;
                    rv_isa_pkg::F3_OR:  alu_op = pipe_pkg::OR;
                    rv_isa_pkg::F3_AND: alu_op = pipe_pkg::AND;
                    default:            illegal = 1'b1;
                endcase
                if (f7 != rv_isa_pkg::F7_BASE &&
                    !(f7 == rv_isa_pkg::F7_SUB && f3 == rv_isa_pkg::F3_ADD_SUB))
                    illegal = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin      // addi only
                use_rs1 = 1'b1;
                use_imm = 1'b1;
                reg_wen = 1'b1;
                illegal = (f3 != rv_isa_pkg::F3_ADD_SUB);
            end
            rv_isa_pkg::LUI: begin
                alu_op  = pipe_pkg::PASS_B;
                imm     = imm_u;
                use_imm = 1'b1;
                reg_wen = 1'b1;
            end
            rv_isa_pkg::LOAD: begin
                use_rs1 = 1'b1;
                use_imm = 1'b1;
                reg_wen = 1'b1;
                mem_rd  = 1'b1;
                illegal = (f3 != rv_isa_pkg::F3_DWORD);
            end
            rv_isa_pkg::STORE: begin
                imm     = imm_s;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_imm = 1'b1;
                mem_wr  = 1'b1;
                illegal = (f3 != rv_isa_pkg::F3_DWORD);
            end
            rv_isa_pkg::BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                is_br   = 1'b1;
                illegal = (f3 != rv_isa_pkg::F3_BEQ && f3 != rv_isa_pkg::F3_BNE);
            end
            rv_isa_pkg::JAL: begin
                alu_op  = pipe_pkg::PASS_B;
                reg_wen = 1'b1;
                is_jal  = 1'b1;
            end
            rv_isa_pkg::SYSTEM: begin
                halt    = (id_inst_i == rv_isa_pkg::EBREAK);
                illegal = !halt;
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin                 // retire as a plain no-op
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
            reg_wen = 1'b0;
            mem_rd  = 1'b0;
            mem_wr  = 1'b0;
            is_br   = 1'b0;
        end
    end

    assign rf.raddr1 = rs1;
    assign rf.raddr2 = rs2;

    // EX beats MEM beats the register file; x0 never forwards
    assign rs1_val = (rs1 == '0) ? '0 :
                     (ex_wen_i && ex_rd_i == rs1) ? ex_result_i :
                     (mem_wen_i && mem_rd_i == rs1) ? mem_result_i : rf.rdata1;
    assign rs2_val = (rs2 == '0) ? '0 :
                     (ex_wen_i && ex_rd_i == rs2) ? ex_result_i :
                     (mem_wen_i && mem_rd_i == rs2) ? mem_result_i : rf.rdata2;

    assign dec_valid = id_valid_i && !halt_seen_q;
    assign load_use  = dec_valid && ex_load_i && ex_rd_i != '0 &&
                       ((use_rs1 && rs1 == ex_rd_i) || (use_rs2 && rs2 == ex_rd_i));
    assign taken     = is_jal || (is_br && ((f3 == rv_isa_pkg::F3_BNE) ^ (rs1_val == rs2_val)));
    assign issue     = dec_valid && !load_use;

    assign stall_o       = load_use;
    assign redirect_o    = issue && taken;
    assign redirect_pc_o = id_pc_i + (is_jal ? imm_j : imm_b);
    assign op_b          = is_jal ? id_pc_i + 64'd4 : (use_imm ? imm : rs2_val);

    // ID/EX control; a stall sends a bubble
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_bus.valid     <= 1'b0;
            ex_bus.reg_wen   <= 1'b0;
            ex_bus.mem_read  <= 1'b0;
            ex_bus.mem_write <= 1'b0;
            ex_bus.illegal   <= 1'b0;
            ex_bus.halt      <= 1'b0;
            halt_seen_q      <= 1'b0;
        end else begin
            ex_bus.valid     <= issue;
            ex_bus.reg_wen   <= issue && reg_wen;
            ex_bus.mem_read  <= issue && mem_rd;
            ex_bus.mem_write <= issue && mem_wr;
            ex_bus.illegal   <= issue && illegal;
            ex_bus.halt      <= issue && halt;
            if (issue && halt)
                halt_seen_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        ex_bus.pc         <= id_pc_i;
        ex_bus.rd         <= rd;
        ex_bus.alu_op     <= alu_op;
        ex_bus.op_a       <= rs1_val;
        ex_bus.op_b       <= op_b;
        ex_bus.store_data <= rs2_val;
        ex_bus.wb_src     <= mem_rd ? pipe_pkg::MEM : pipe_pkg::ALU;
    end
endmodule

//--- logic/exec_stage.sv
// the ALU result replaces op_a in the EX/MEM bundle; forwarding outputs are combinational
`timescale 1ns/10ps

module exec_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    stage_bus_if.dst             ex_bus,
    stage_bus_if.src             mem_bus,
    output rv_isa_pkg::reg_idx_t ex_rd_o,
    output logic                 ex_wen_o,
    output logic                 ex_load_o,
    output rv_isa_pkg::xlen_t    ex_result_o
);
    rv_isa_pkg::xlen_t alu_res;

    always_comb begin
        case (ex_bus.alu_op)
            pipe_pkg::ADD:    alu_res = ex_bus.op_a + ex_bus.op_b;
            pipe_pkg::SUB:    alu_res = ex_bus.op_a - ex_bus.op_b;
            pipe_pkg::AND:    alu_res = ex_bus.op_a & ex_bus.op_b;
            pipe_pkg::OR:     alu_res = ex_bus.op_a | ex_bus.op_b;
            pipe_pkg::XOR:    alu_res = ex_bus.op_a ^ ex_bus.op_b;
            pipe_pkg::SLT:    alu_res = {63'b0, $signed(ex_bus.op_a) < $signed(ex_bus.op_b)};
            pipe_pkg::PASS_B: alu_res = ex_bus.op_b;
            default:          alu_res = '0;
        endcase
    end

    assign ex_rd_o     = ex_bus.rd;
    assign ex_wen_o    = ex_bus.valid && ex_bus.reg_wen;
    assign ex_load_o   = ex_bus.valid && ex_bus.mem_read;  // data not ready yet
    assign ex_result_o = alu_res;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_bus.valid     <= 1'b0;
            mem_bus.reg_wen   <= 1'b0;
            mem_bus.mem_read  <= 1'b0;
            mem_bus.mem_write <= 1'b0;
            mem_bus.illegal   <= 1'b0;
            mem_bus.halt      <= 1'b0;
        end else begin
            mem_bus.valid     <= ex_bus.valid;
            mem_bus.reg_wen   <= ex_bus.valid && ex_bus.reg_wen;
            mem_bus.mem_read  <= ex_bus.valid && ex_bus.mem_read;
            mem_bus.mem_write <= ex_bus.valid && ex_bus.mem_write;
            mem_bus.illegal   <= ex_bus.valid && ex_bus.illegal;
            mem_bus.halt      <= ex_bus.valid && ex_bus.halt;
        end
    end

    always_ff @(posedge clk) begin
        mem_bus.pc         <= ex_bus.pc;
        mem_bus.rd         <= ex_bus.rd;
        mem_bus.alu_op     <= ex_bus.alu_op;
        mem_bus.op_a       <= alu_res;     // result or address
        mem_bus.op_b       <= ex_bus.op_b;
        mem_bus.store_data <= ex_bus.store_data;
        mem_bus.wb_src     <= ex_bus.wb_src;
    end
endmodule

//--- logic/mem_stage.sv
// doubleword accesses only; the low address bits are ignored and the index wraps at DMEM_WORDS
`timescale 1ns/10ps

module mem_stage #(
    parameter int DMEM_WORDS = 32
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    stage_bus_if.dst             mem_bus,
    stage_bus_if.src             wb_bus,
    output rv_isa_pkg::reg_idx_t mem_rd_o,
    output logic                 mem_wen_o,
    output rv_isa_pkg::xlen_t    mem_result_o
);
    localparam int IDX_W = pipe_pkg::dmem_idx_bits(DMEM_WORDS);

    rv_isa_pkg::xlen_t dmem [DMEM_WORDS];
    logic [IDX_W-1:0]  idx;

    assign idx = mem_bus.op_a[pipe_pkg::DWORD_SHIFT +: IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DMEM_WORDS; i++)
                dmem[i] <= '0;
        end else if (mem_bus.valid && mem_bus.mem_write) begin
            dmem[idx] <= mem_bus.store_data;  // sd
        end
    end

    assign mem_result_o = (mem_bus.wb_src == pipe_pkg::MEM) ? dmem[idx] : mem_bus.op_a;
    assign mem_rd_o     = mem_bus.rd;
    assign mem_wen_o    = mem_bus.valid && mem_bus.reg_wen;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_bus.valid     <= 1'b0;
            wb_bus.reg_wen   <= 1'b0;
            wb_bus.mem_read  <= 1'b0;
            wb_bus.mem_write <= 1'b0;
            wb_bus.illegal   <= 1'b0;
            wb_bus.halt      <= 1'b0;
        end else begin
            wb_bus.valid     <= mem_bus.valid;
            wb_bus.reg_wen   <= mem_bus.valid && mem_bus.reg_wen;
            wb_bus.mem_read  <= mem_bus.valid && mem_bus.mem_read;
            wb_bus.mem_write <= mem_bus.valid && mem_bus.mem_write;
            wb_bus.illegal   <= mem_bus.valid && mem_bus.illegal;
            wb_bus.halt      <= mem_bus.valid && mem_bus.halt;
        end
    end

    always_ff @(posedge clk) begin
        wb_bus.pc         <= mem_bus.pc;
        wb_bus.rd         <= mem_bus.rd;
        wb_bus.alu_op     <= mem_bus.alu_op;
        wb_bus.op_a       <= mem_result_o;  // write-back value
        wb_bus.op_b       <= mem_bus.op_b;
        wb_bus.store_data <= mem_bus.store_data;
        wb_bus.wb_src     <= mem_bus.wb_src;
    end
endmodule

//--- logic/reg_file.sv
// x0 reads as zero; a write is seen by a read in the same cycle
`timescale 1ns/10ps

module reg_file (
    input  logic      clk,
    input  logic      rst_n_i,
    regfile_if.rd_srv rf_rd,
    regfile_if.wr     rf_wr
);
    rv_isa_pkg::xlen_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (rf_wr.wen && rf_wr.waddr != '0) begin
            regs[rf_wr.waddr] <= rf_wr.wdata;  // x0 writes dropped
        end
    end

    assign rf_rd.rdata1 = (rf_rd.raddr1 == '0) ? '0 :
                          (rf_wr.wen && rf_wr.waddr == rf_rd.raddr1) ? rf_wr.wdata :
                          regs[rf_rd.raddr1];
    assign rf_rd.rdata2 = (rf_rd.raddr2 == '0) ? '0 :
                          (rf_wr.wen && rf_wr.waddr == rf_rd.raddr2) ? rf_wr.wdata :
                          regs[rf_rd.raddr2];
endmodule

//--- logic/rv_core_top.sv
// no bus handshake; the instruction memory must answer in the same cycle as imem_addr_o
`timescale 1ns/10ps

module rv_core_top #(
    parameter rv_isa_pkg::xlen_t RESET_PC   = '0,
    parameter int                DMEM_WORDS = 32
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    output rv_isa_pkg::xlen_t    imem_addr_o,
    input  rv_isa_pkg::inst_t    imem_rdata_i,
    output logic                 retire_valid_o,
    output rv_isa_pkg::xlen_t    retire_pc_o,
    output rv_isa_pkg::reg_idx_t retire_rd_o,
    output rv_isa_pkg::xlen_t    retire_data_o,
    output logic                 retire_illegal_o,
    output logic                 halt_o
);
    logic                 id_valid, id_stall, id_redirect, halt_q;
    rv_isa_pkg::xlen_t    id_pc, redirect_pc, ex_result, mem_result;
    rv_isa_pkg::inst_t    id_inst;
    rv_isa_pkg::reg_idx_t ex_rd, mem_rd;
    logic                 ex_wen, ex_load, mem_wen;

    stage_bus_if ex_bus ();
    stage_bus_if mem_bus ();
    stage_bus_if wb_bus ();
    regfile_if   rf_bus ();

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .stall_i(id_stall), .redirect_i(id_redirect), .redirect_pc_i(redirect_pc),
        .imem_addr_o(imem_addr_o), .imem_rdata_i(imem_rdata_i), .halt_i(halt_o),
        .id_valid_o(id_valid), .id_pc_o(id_pc), .id_inst_o(id_inst)
    );

    decode_stage decode_stage_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .id_valid_i(id_valid), .id_pc_i(id_pc), .id_inst_i(id_inst),
        .rf(rf_bus.rd),
        .ex_rd_i(ex_rd), .ex_wen_i(ex_wen), .ex_load_i(ex_load), .ex_result_i(ex_result),
        .mem_rd_i(mem_rd), .mem_wen_i(mem_wen), .mem_result_i(mem_result),
        .stall_o(id_stall), .redirect_o(id_redirect), .redirect_pc_o(redirect_pc),
        .ex_bus(ex_bus.src)
    );

    exec_stage exec_stage_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .ex_bus(ex_bus.dst), .mem_bus(mem_bus.src),
        .ex_rd_o(ex_rd), .ex_wen_o(ex_wen), .ex_load_o(ex_load), .ex_result_o(ex_result)
    );

    mem_stage #(.DMEM_WORDS(DMEM_WORDS)) mem_stage_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .mem_bus(mem_bus.dst), .wb_bus(wb_bus.src),
        .mem_rd_o(mem_rd), .mem_wen_o(mem_wen), .mem_result_o(mem_result)
    );

    reg_file reg_file_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .rf_rd(rf_bus.rd_srv), .rf_wr(rf_bus.wr)
    );

    // writeback straight from the MEM/WB bundle
    assign rf_bus.wen   = wb_bus.valid && wb_bus.reg_wen;
    assign rf_bus.waddr = wb_bus.rd;
    assign rf_bus.wdata = wb_bus.op_a;

    assign retire_valid_o   = wb_bus.valid;
    assign retire_pc_o      = wb_bus.pc;
    assign retire_rd_o      = wb_bus.reg_wen ? wb_bus.rd : '0;
    assign retire_data_o    = wb_bus.op_a;
    assign retire_illegal_o = wb_bus.illegal;

    always_ff @(posedge clk) begin
        if (!rst_n_i)
            halt_q <= 1'b0;
        else if (wb_bus.valid && wb_bus.halt)
            halt_q <= 1'b1;                // sticky until reset
    end

    assign halt_o = halt_q || (wb_bus.valid && wb_bus.halt);  // high in the ebreak retire cycle
endmodule

//--- bench/core_asserts.sv
// bound into rv_core_top; checks assume the synchronous active-low reset of the core
`timescale 1ns/10ps

module core_asserts (
    input logic clk,
    input logic rst_n_i,
    input logic retire_valid_i,
    input logic halt_i,
    input logic stall_i,
    input logic redirect_i
);
    int unsigned failures = 0;             // collected by the testbench

    reset_quiet: assert property (@(posedge clk) $rose(rst_n_i) |-> !retire_valid_i && !halt_i)
        else begin
            $error("retire or halt active in the first cycle after reset");
            failures++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n_i) !$fell(halt_i))
        else begin
            $error("halt_o fell without a reset");
            failures++;
        end

    // the ebreak itself retires in the cycle halt rises
    quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n_i)
                                       halt_i |=> !retire_valid_i)
        else begin
            $error("retire seen after halt");
            failures++;
        end

    // nothing stalls or redirects in the squashed slot
    redirect_squash: assert property (@(posedge clk) disable iff (!rst_n_i)
                                      redirect_i |=> !(stall_i || redirect_i))
        else begin
            $error("stall or redirect in the cycle after a redirect");
            failures++;
        end
endmodule

bind rv_core_top core_asserts core_asserts_inst (
    .clk(clk), .rst_n_i(rst_n_i),
    .retire_valid_i(retire_valid_o), .halt_i(halt_o),
    .stall_i(id_stall), .redirect_i(id_redirect)
);

//--- bench/core_tb.sv
// program starts at address 0 and is at most 32 rows; addresses past the table read as ebreak
`timescale 1ns/10ps

module core_tb;
    localparam int HALF_PERIOD = 50;
    localparam int PROG_LEN    = 32;
    localparam int RETIRE_WAIT = 20;     // cycles allowed between two retires
    localparam int HALT_WINDOW = 30;     // cycles watched after ebreak

    logic                 clk;
    logic                 rst_n;
    rv_isa_pkg::xlen_t    imem_addr;
    rv_isa_pkg::inst_t    imem_rdata;
    logic                 retire_valid;
    rv_isa_pkg::xlen_t    retire_pc;
    rv_isa_pkg::reg_idx_t retire_rd;
    rv_isa_pkg::xlen_t    retire_data;
    logic                 retire_illegal;
    logic                 halt;

    // program table, one row per instruction
    rv_isa_pkg::inst_t    prog_inst [PROG_LEN];
    logic                 prog_ret  [PROG_LEN];
    rv_isa_pkg::reg_idx_t prog_rd   [PROG_LEN];
    rv_isa_pkg::xlen_t    prog_data [PROG_LEN];
    logic                 prog_ill  [PROG_LEN];
    string                prog_name [PROG_LEN];
    int                   n_rows;
    string                section;
    int                   errors;
    int                   timeouts;
    int                   asrt_fails;

    rv_core_top #(.RESET_PC(64'h0), .DMEM_WORDS(32)) rv_core_top_inst (
        .clk(clk), .rst_n_i(rst_n),
        .imem_addr_o(imem_addr), .imem_rdata_i(imem_rdata),
        .retire_valid_o(retire_valid), .retire_pc_o(retire_pc), .retire_rd_o(retire_rd),
        .retire_data_o(retire_data), .retire_illegal_o(retire_illegal),
        .halt_o(halt)
    );

    always #HALF_PERIOD clk = ~clk;

    // instruction memory, answered in the same cycle
    always_comb begin
        if (imem_addr[63:7] == '0)                     // 32 rows of 4 bytes
            imem_rdata = prog_inst[imem_addr[6:2]];
        else
            imem_rdata = rv_isa_pkg::EBREAK;
    end

    function automatic rv_isa_pkg::inst_t op_word(input logic [2:0] f3, input logic sub,
                                                  input int rd, input int rs1, input int rs2);
        return {sub ? rv_isa_pkg::F7_SUB : rv_isa_pkg::F7_BASE, rs2[4:0], rs1[4:0], f3,
                rd[4:0], rv_isa_pkg::OP};
    endfunction

    function automatic rv_isa_pkg::inst_t addi_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], rv_isa_pkg::F3_ADD_SUB, rd[4:0], rv_isa_pkg::OP_IMM};
    endfunction

    function automatic rv_isa_pkg::inst_t lui_word(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], rv_isa_pkg::LUI};
    endfunction

    function automatic rv_isa_pkg::inst_t ld_word(input int rd, input int rs1, input int off);
        return {off[11:0], rs1[4:0], rv_isa_pkg::F3_DWORD, rd[4:0], rv_isa_pkg::LOAD};
    endfunction

    function automatic rv_isa_pkg::inst_t sd_word(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], rv_isa_pkg::F3_DWORD, off[4:0],
                rv_isa_pkg::STORE};
    endfunction

    function automatic rv_isa_pkg::inst_t branch_word(input logic [2:0] f3, input int rs1,
                                                      input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11],
                rv_isa_pkg::BRANCH};
    endfunction

    function automatic rv_isa_pkg::inst_t jal_word(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_isa_pkg::JAL};
    endfunction

    task automatic begin_section(input string name);
        section = name;
    endtask

    task automatic append_row(input rv_isa_pkg::inst_t inst, input logic ret, input int rd,
                              input rv_isa_pkg::xlen_t data, input logic ill);
        if (n_rows < PROG_LEN) begin
            prog_inst[n_rows] = inst;
            prog_ret[n_rows]  = ret;
            prog_rd[n_rows]   = rd[4:0];
            prog_data[n_rows] = data;
            prog_ill[n_rows]  = ill;
            prog_name[n_rows] = section;
            n_rows++;
        end
    endtask

    task automatic retire_row(input rv_isa_pkg::inst_t inst, input int rd,
                              input rv_isa_pkg::xlen_t data);
        append_row(inst, 1'b1, rd, data, 1'b0);
    endtask

    task automatic skip_row(input rv_isa_pkg::inst_t inst);
        append_row(inst, 1'b0, 0, '0, 1'b0);       // wrong path, squashed
    endtask

    task automatic illegal_row(input rv_isa_pkg::inst_t inst);
        append_row(inst, 1'b1, 0, '0, 1'b1);
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++)
            prog_inst[i] = rv_isa_pkg::EBREAK;
        n_rows = 0;
        begin_section("alu_forward");
        retire_row(lui_word(1, 32'h12345), 1, 64'h1234_5000);
        retire_row(addi_word(2, 0, -7), 2, 64'hFFFF_FFFF_FFFF_FFF9);
        retire_row(addi_word(3, 1, 32'h67), 3, 64'h1234_5067);              // x1 two back
        retire_row(op_word(rv_isa_pkg::F3_ADD_SUB, 1'b0, 4, 3, 2), 4, 64'h1234_5060);
        retire_row(op_word(rv_isa_pkg::F3_ADD_SUB, 1'b1, 5, 4, 1), 5, 64'h60);
        retire_row(op_word(rv_isa_pkg::F3_AND, 1'b0, 6, 3, 2), 6, 64'h1234_5061);
        retire_row(op_word(rv_isa_pkg::F3_OR, 1'b0, 8, 5, 1), 8, 64'h1234_5060);
        retire_row(op_word(rv_isa_pkg::F3_XOR, 1'b0, 7, 5, 2), 7, 64'hFFFF_FFFF_FFFF_FF99);
        retire_row(op_word(rv_isa_pkg::F3_SLT, 1'b0, 9, 2, 5), 9, 64'h1);   // -7 < 0x60
        retire_row(op_word(rv_isa_pkg::F3_SLT, 1'b0, 10, 5, 2), 10, 64'h0);
        retire_row(addi_word(0, 5, 1), 0, '0);                            // x0 write dropped
        retire_row(op_word(rv_isa_pkg::F3_ADD_SUB, 1'b0, 11, 0, 5), 11, 64'h60);
        begin_section("load_store");
        retire_row(addi_word(12, 0, 32'h100), 12, 64'h100);
        retire_row(sd_word(4, 12, 8), 0, '0);
        retire_row(sd_word(2, 12, 16), 0, '0);
        retire_row(ld_word(13, 12, 8), 13, 64'h1234_5060);
        retire_row(op_word(rv_isa_pkg::F3_ADD_SUB, 1'b0, 14, 13, 2), 14, 64'h1234_5059);
        retire_row(ld_word(15, 12, 16), 15, 64'hFFFF_FFFF_FFFF_FFF9);
        retire_row(op_word(rv_isa_pkg::F3_ADD_SUB, 1'b1, 16, 5, 15), 16, 64'h67);
        begin_section("branch");
        retire_row(branch_word(rv_isa_pkg::F3_BEQ, 5, 11, 8), 0, '0);      // taken
        skip_row(addi_word(17, 0, 1));
        retire_row(branch_word(rv_isa_pkg::F3_BNE, 5, 4, 8), 0, '0);       // taken
        skip_row(addi_word(17, 0, 2));
        retire_row(branch_word(rv_isa_pkg::F3_BEQ, 5, 4, 8), 0, '0);       // falls through
        retire_row(addi_word(17, 0, 3), 17, 64'h3);
        retire_row(jal_word(18, 8), 18, 64'h68);                          // link = 25*4+4
        skip_row(addi_word(17, 0, 4));
        retire_row(op_word(rv_isa_pkg::F3_ADD_SUB, 1'b0, 19, 18, 17), 19, 64'h6B);
        begin_section("illegal");
        illegal_row(32'h0252_88B3);                                       // mul x17, x5, x5
        illegal_row(32'h0000_088B);                                       // custom-0, rd x17
        retire_row(op_word(rv_isa_pkg::F3_ADD_SUB, 1'b0, 20, 17, 0), 20, 64'h3);
        begin_section("halt");
        retire_row(rv_isa_pkg::EBREAK, 0, '0);
    endtask

    task automatic compare_field(input int row, input string field,
                                 input rv_isa_pkg::xlen_t exp, input rv_isa_pkg::xlen_t act);
        assert (act === exp) else begin
            $display("ERROR %s row %0d %s: expected %h, actual %h",
                     prog_name[row], row, field, exp, act);
            errors++;
        end
    endtask

    // outputs settle after the rising edge, so sample on the falling one
    task automatic wait_retire(output bit got);
        got = 1'b0;
        for (int c = 0; c < RETIRE_WAIT && !got; c++) begin
            @(negedge clk);
            got = retire_valid;
        end
    endtask

    initial begin
        bit got;
        clk      = 1'b0;
        rst_n    = 1'b0;
        errors   = 0;
        timeouts = 0;
        load_program();
        repeat (10) @(posedge clk);
        #5 rst_n = 1'b1;

        for (int i = 0; i < n_rows; i++) begin
            if (prog_ret[i]) begin
                wait_retire(got);
                if (!got) begin
                    $display("TIMEOUT: row %0d (%s) did not retire within %0d cycles",
                             i, prog_name[i], RETIRE_WAIT);
                    timeouts++;
                    break;
                end
                compare_field(i, "pc", 64'(i * 4), retire_pc);
                compare_field(i, "rd", 64'(prog_rd[i]), 64'(retire_rd));
                compare_field(i, "illegal", 64'(prog_ill[i]), 64'(retire_illegal));
                if (prog_rd[i] != '0)
                    compare_field(i, "data", prog_data[i], retire_data);
            end
        end

        if (timeouts == 0) begin
            assert (halt === 1'b1) else begin
                $display("halt_o did not rise when ebreak retired");
                errors++;
            end
            for (int c = 0; c < HALT_WINDOW; c++) begin
                @(negedge clk);
                assert (retire_valid === 1'b0) else begin
                    $display("an instruction retired after the core halted");
                    errors++;
                end
                assert (halt === 1'b1) else begin
                    $display("halt_o dropped while the core was halted");
                    errors++;
                end
            end
        end

        asrt_fails = rv_core_top_inst.core_asserts_inst.failures;
        $display("checks failed: %0d, assertion failures: %0d, timeouts: %0d",
                 errors, asrt_fails, timeouts);
        if (errors == 0 && timeouts == 0 && asrt_fails == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end
endmodule

//--- all.f
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/pipe_bus_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/reg_file.sv
logic/rv_core_top.sv
bench/core_asserts.sv
bench/core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - logic/rv_isa_pkg.sv
      - logic/pipe_pkg.sv
      - logic/pipe_bus_if.sv
      - logic/fetch_stage.sv
      - logic/decode_stage.sv
      - logic/exec_stage.sv
      - logic/mem_stage.sv
      - logic/reg_file.sv
      - logic/rv_core_top.sv
  - target: test
    files:
      - bench/core_asserts.sv
      - bench/core_tb.sv
